// File: z80QuadrantCore.f
+incdir+common
common/z80DataPkg.sv
common/z80OpcodePkg.sv
decoder/opDecoder.sv
alu/aluExecute.sv
src/regResult.sv
src/z80QuadrantCore.sv
tests/z80QuadrantCore_props.sv
tests/z80QuadrantCore_tb.sv

// File: Makefile
# Verilator build and run of the quadrant unit testbench.
VERILATOR ?= verilator
TOP       ?= z80QuadrantCore_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= z80QuadrantCore.f
VFLAGS    ?= --binary --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/z80QuadrantCore_tb.sv
// Testbench for the quadrant unit; builds op tables with a reference model and applies them.
`timescale 1ns/1ps
`include "z80_defs.svh"

module z80QuadrantCore_tb
    import z80DataPkg::*;
    import z80OpcodePkg::*;
();

    localparam int pollLimit = 30; // Polls of 10 ns allowed per clock edge.

    typedef struct {
        byteT   opcode;
        byteT   imm;
        regIdxT view;
        byteT   expByte;
        flagsT  expFlags;
        int     idleAfter;
    } rowT;

    logic   clk;
    logic   reset;
    logic   opValid;
    byteT   opcode;
    byteT   immediate;
    regIdxT readSel;
    byteT   readData;
    flagsT  flags;

    byteT  mRegs [`Z80_REG_COUNT]; // Model of the register file.
    flagsT mFlags;
    byteT  lfsrState;
    rowT   rows [$];
    int    edgeCount;
    int    errorCount;
    int    checkCount;
    bit    timedOut;

    z80QuadrantCore i_z80QuadrantCore (
        .clk       (clk),
        .reset     (reset),
        .opValid   (opValid),
        .opcode    (opcode),
        .immediate (immediate),
        .readSel   (readSel),
        .readData  (readData),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        edgeCount = 0;
        forever begin
            #50;
            clk = 1'b1;
            edgeCount++;
            #50;
            clk = 1'b0;
        end
    end

    // 8-bit Fibonacci LFSR, taps 8, 6, 5, 4.
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[7] ^ lfsrState[5] ^ lfsrState[4] ^ lfsrState[3];
        lfsrState = {lfsrState[6:0], fb};
        return fb;
    endfunction

    function automatic byteT randomByte();
        byteT b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsrBit()};
        end
        return b;
    endfunction

    function automatic logic evenParity(byteT b);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) ones++;
        end
        return (ones % 2) == 0;
    endfunction

    // Steps the model by one opcode and queues the register and flags it should leave.
    task automatic addRow(byteT op, byteT imm, int idleAfter);
        rowT        row;
        logic [2:0] y;
        logic [2:0] z;
        byteT       v;
        byteT       a;
        byteT       corr;
        logic       carry;
        y = op[5:3];
        z = op[2:0];
        row.view = regA;
        if (op[7:6] == 2'b00 && z >= 3'd4 && z <= 3'd6 && y != `Z80_REG_HL_MEM) begin
            row.view = y;
            v = mRegs[y];
            if (z == 3'd4) begin
                mRegs[y] = v + 8'd1;
                mFlags.h = ({4'h0, v[3:0]} + 8'd1) > 8'h0F;
                mFlags.pv = (v == 8'h7F);
                mFlags.n = 1'b0;
            end else if (z == 3'd5) begin
                mRegs[y] = v - 8'd1;
                mFlags.h = (v[3:0] < 4'd1);
                mFlags.pv = (v == 8'h80);
                mFlags.n = 1'b1;
            end else begin
                mRegs[y] = imm; // Loads leave F alone.
            end
            if (z != 3'd6) begin
                mFlags.s = mRegs[y][7];
                mFlags.z = (mRegs[y] == 8'h00);
            end
        end else if (op[7:6] == 2'b00 && z == 3'd7) begin
            a = mRegs[regA];
            case (y)
                3'd0: begin
                    mFlags.c = a[7];
                    a = {a[6:0], a[7]};
                end
                3'd1: begin
                    mFlags.c = a[0];
                    a = {a[0], a[7:1]};
                end
                3'd2: begin
                    carry = mFlags.c;
                    mFlags.c = a[7];
                    a = {a[6:0], carry};
                end
                3'd3: begin
                    carry = mFlags.c;
                    mFlags.c = a[0];
                    a = {carry, a[7:1]};
                end
                3'd4: begin
                    corr = 8'h00;
                    carry = mFlags.c;
                    if (mFlags.h || a[3:0] > 4'd9) corr = corr | 8'h06;
                    if (mFlags.c || a > 8'h99) begin
                        corr = corr | 8'h60;
                        carry = 1'b1;
                    end
                    mFlags.h = mFlags.n ? (mFlags.h && a[3:0] < 4'd6) : (a[3:0] > 4'd9);
                    a = mFlags.n ? a - corr : a + corr;
                    mFlags.c = carry;
                    mFlags.s = a[7];
                    mFlags.z = (a == 8'h00);
                    mFlags.pv = evenParity(a);
                end
                3'd5: begin
                    a = ~a;
                    mFlags.h = 1'b1;
                    mFlags.n = 1'b1;
                end
                3'd6: mFlags.c = 1'b1;
                default: begin
                    mFlags.h = mFlags.c;
                    mFlags.c = ~mFlags.c;
                end
            endcase
            if (y <= 3'd3 || y >= 3'd6) begin
                mFlags.n = 1'b0; // Rotates, SCF and CCF clear N.
                if (y != 3'd7) mFlags.h = 1'b0;
            end
            mRegs[regA] = a;
        end
        row.opcode = op;
        row.imm = imm;
        row.expByte = mRegs[row.view];
        row.expFlags = mFlags;
        row.idleAfter = idleAfter;
        rows.push_back(row);
    endtask

    // Sets C with SCF/CCF, then H and N with an INC or DEC of B.
    task automatic prepareFlags(logic n, logic h, logic c);
        addRow(8'h37, 8'h00, 1);
        if (!c) addRow(8'h3F, 8'h00, 1);
        addRow(8'h06, n ? (h ? 8'h10 : 8'h11) : (h ? 8'h0F : 8'h01), 1);
        addRow(n ? 8'h05 : 8'h04, 8'h00, 1);
    endtask

    task automatic waitEdges(int count);
        int target;
        int polls;
        target = edgeCount + count;
        polls = 0;
        while (edgeCount < target && polls < pollLimit * count) begin
            #10;
            polls++;
        end
        if (edgeCount < target) begin
            timedOut = 1'b1;
            $display("Timeout at %0t: the clock edge never arrived", $time);
        end
    endtask

    task automatic checkByte(byteT actual, byteT expected, string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s read %02h, expected %02h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic checkFlags(flagsT actual, flagsT expected, string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s flags szhpnc %06b, expected %06b",
                     $time, what, actual, expected);
        end
    endtask

    // Issues the queued rows, each checked two edges after its strobe.
    task automatic runRows(string name);
        int slots [$];
        int startErrors;
        int idx;
        startErrors = errorCount;
        foreach (rows[i]) begin
            slots.push_back(i);
            repeat (rows[i].idleAfter)
                slots.push_back(-1);
        end
        for (int s = 0; s < slots.size() + 2 && !timedOut; s++) begin
            opValid = 1'b0;
            opcode = 8'h3C; // INC A on the bus while idle.
            immediate = 8'hA5;
            if (s < slots.size() && slots[s] >= 0) begin
                opValid = 1'b1;
                opcode = rows[slots[s]].opcode;
                immediate = rows[slots[s]].imm;
            end
            idx = (s >= 2) ? slots[s - 2] : -1;
            if (idx >= 0)
                readSel = rows[idx].view;
            #40;
            if (idx >= 0) begin
                checkByte(readData, rows[idx].expByte,
                          $sformatf("%s op %02h", name, rows[idx].opcode));
                checkFlags(flags, rows[idx].expFlags,
                           $sformatf("%s op %02h", name, rows[idx].opcode));
            end
            waitEdges(1);
        end
        $display("Test %s: %0d ops, %0d errors", name, rows.size(), errorCount - startErrors);
        rows.delete();
    endtask

    initial begin
        byteT incVals [5];
        byteT aVals [3];
        byteT accOps [7];
        byteT daaVals [6];
        byteT mixOps [19];
        int   startErrors;
        reset = 1'b1;
        opValid = 1'b0;
        opcode = 8'h00;
        immediate = 8'h00;
        readSel = regB;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        lfsrState = 8'd59;
        foreach (mRegs[i]) mRegs[i] = 8'h00;
        mFlags = flagsT'(0);
        #5;
        waitEdges(3);
        reset = 1'b0;

        startErrors = errorCount;
        for (int r = 0; r < `Z80_REG_COUNT; r++) begin
            readSel = regIdxT'(r);
            #10;
            checkByte(readData, 8'h00, $sformatf("reset register %0d", r));
        end
        checkFlags(flags, flagsT'(0), "reset");
        $display("Test reset: %0d errors", errorCount - startErrors);
        waitEdges(1);

        for (int r = 0; r < `Z80_REG_COUNT; r++) begin
            if (r != 6) addRow({2'b00, regIdxT'(r), 3'b110}, randomByte(), 1);
        end
        runRows("load");

        incVals = '{8'h7F, 8'h80, 8'h0F, 8'h00, 8'hFF};
        addRow(8'h37, 8'h00, 1);
        foreach (incVals[i]) begin
            addRow(8'h06, incVals[i], 1);
            addRow(8'h04, 8'h00, 1);
            addRow(8'h0E, incVals[i], 1);
            addRow(8'h0D, 8'h00, 1);
            if (i == 2) addRow(8'h3F, 8'h00, 1); // Later values run with C clear.
        end
        runRows("incdec");

        aVals = '{8'h81, 8'h5A, randomByte()};
        accOps = '{8'h07, 8'h0F, 8'h17, 8'h1F, 8'h2F, 8'h37, 8'h3F};
        foreach (aVals[i]) begin
            for (int c = 0; c < 2; c++) begin
                foreach (accOps[k]) begin
                    addRow(8'h3E, aVals[i], 1);
                    addRow(8'h37, 8'h00, 1); // Fresh C before every op.
                    if (c == 0) addRow(8'h3F, 8'h00, 1);
                    addRow(accOps[k], 8'h00, 1);
                end
            end
        end
        runRows("accumulator");

        daaVals = '{8'h9A, 8'h15, 8'h3C, 8'hA0, 8'h0F, randomByte()};
        foreach (daaVals[i]) begin
            for (int f = 0; f < 8; f++) begin
                prepareFlags(f[2], f[1], f[0]);
                addRow(8'h3E, daaVals[i], 1);
                addRow(8'h27, 8'h00, 1);
            end
        end
        runRows("daa");

        mixOps = '{8'h3E, 8'h00, 8'h3C, 8'h01, 8'h18, 8'h34, 8'h35, 8'h36, 8'h2F, 8'h22,
                   8'h0A, 8'h3D, 8'h17, 8'h03, 8'h06, 8'h05, 8'h27, 8'h37, 8'h1F};
        foreach (mixOps[i]) begin
            addRow(mixOps[i], randomByte(), 0);
        end
        runRows("pipeline");

        $display("Summary: %0d checks, %0d errors, timeout %0d", checkCount, errorCount,
                 timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tests/z80QuadrantCore_props.sv
// Concurrent checks on the write strobes and flags of the quadrant unit, bound into its top level.
`timescale 1ns/1ps
`include "z80_defs.svh"

module z80QuadrantCore_props
    import z80DataPkg::*;
    import z80OpcodePkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      opValid,
    input decodedOpT decodedOp,
    input logic      regWrite,
    input logic      flagWrite,
    input flagsT     flags
);

    logic seenReset; // History is meaningful once reset has been sampled.

    always_ff @(posedge clk) begin
        if (reset) begin
            seenReset <= 1'b1;
        end
    end

    noWriteAfterReset: assert property (@(posedge clk)
        seenReset && $past(reset) |-> !regWrite && !flagWrite)
        else $error("write strobe active in the cycle after reset");

    noMemTarget: assert property (@(posedge clk) disable iff (reset)
        regWrite |-> decodedOp.target != `Z80_REG_HL_MEM)
        else $error("register write aimed at code 6");

    // An op changes F two edges after its strobe.
    flagsHeld: assert property (@(posedge clk) disable iff (reset)
        seenReset && !$past(reset) && !$past(opValid) && !$past(opValid, 2) |-> $stable(flags))
        else $error("flags changed with no op in flight");

endmodule

bind z80QuadrantCore z80QuadrantCore_props i_props (
    .clk       (clk),
    .reset     (reset),
    .opValid   (opValid),
    .decodedOp (decodedOp),
    .regWrite  (regWrite),
    .flagWrite (flagWrite),
    .flags     (flags)
);

// File: src/z80QuadrantCore.sv
// Top level of the quadrant unit: decode, execute and result stages with two-edge latency.
`timescale 1ns/1ps

module z80QuadrantCore
    import z80DataPkg::*;
    import z80OpcodePkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   opValid,
    input  byteT   opcode,
    input  byteT   immediate,
    input  regIdxT readSel,
    output byteT   readData,
    output flagsT  flags
);

    decodedOpT decodedOp;
    byteT      operand;
    flagsT     curFlags;
    logic      regWrite;
    logic      flagWrite;
    byteT      result;
    flagsT     newFlags;

    opDecoder i_opDecoder (
        .clk       (clk),
        .reset     (reset),
        .opValid   (opValid),
        .opcode    (opcode),
        .immediate (immediate),
        .decodedOp (decodedOp)
    );

    aluExecute i_aluExecute (
        .decodedOp (decodedOp),
        .operand   (operand),
        .curFlags  (curFlags),
        .regWrite  (regWrite),
        .flagWrite (flagWrite),
        .result    (result),
        .newFlags  (newFlags)
    );

    regResult i_regResult (
        .clk       (clk),
        .reset     (reset),
        .readSel   (readSel),
        .target    (decodedOp.target),
        .regWrite  (regWrite),
        .result    (result),
        .flagWrite (flagWrite),
        .newFlags  (newFlags),
        .operand   (operand),
        .curFlags  (curFlags),
        .readData  (readData),
        .flags     (flags)
    );

endmodule

// File: src/regResult.sv
// Result stage: register file and F register, written back from execute, with the read ports.
`timescale 1ns/1ps
`include "z80_defs.svh"

module regResult
    import z80DataPkg::*;
    import z80OpcodePkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  regIdxT readSel,
    input  regIdxT target,
    input  logic   regWrite,
    input  byteT   result,
    input  logic   flagWrite,
    input  flagsT  newFlags,
    output byteT   operand,
    output flagsT  curFlags,
    output byteT   readData,
    output flagsT  flags
);

    byteT regFile [`Z80_REG_COUNT];
    byteT fReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `Z80_REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWrite && (target != `Z80_REG_HL_MEM)) begin
            regFile[target] <= result;
        end
    end

    // F keeps the Z80 bit layout; bits 5 and 3 stay zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            fReg <= '0;
        end else if (flagWrite) begin
            fReg                <= '0;
            fReg[`Z80_FLAG_S]   <= newFlags.s;
            fReg[`Z80_FLAG_Z]   <= newFlags.z;
            fReg[`Z80_FLAG_H]   <= newFlags.h;
            fReg[`Z80_FLAG_PV]  <= newFlags.pv;
            fReg[`Z80_FLAG_N]   <= newFlags.n;
            fReg[`Z80_FLAG_C]   <= newFlags.c;
        end
    end

    assign flags.s  = fReg[`Z80_FLAG_S];
    assign flags.z  = fReg[`Z80_FLAG_Z];
    assign flags.h  = fReg[`Z80_FLAG_H];
    assign flags.pv = fReg[`Z80_FLAG_PV];
    assign flags.n  = fReg[`Z80_FLAG_N];
    assign flags.c  = fReg[`Z80_FLAG_C];

    assign curFlags = flags;

    // Code 6 has no register behind it.
    assign operand  = (target == `Z80_REG_HL_MEM) ? '0 : regFile[target];
    assign readData = (readSel == `Z80_REG_HL_MEM) ? '0 : regFile[readSel];

endmodule

// File: alu/aluExecute.sv
// Execute stage: computes the new register value and flags for one decoded quadrant operation.
`timescale 1ns/1ps
`include "z80_defs.svh"

module aluExecute
    import z80DataPkg::*;
    import z80OpcodePkg::*;
(
    input  decodedOpT decodedOp,
    input  byteT      operand,
    input  flagsT     curFlags,
    output logic      regWrite,
    output logic      flagWrite,
    output byteT      result,
    output flagsT     newFlags
);

    byteT incRes;
    byteT decRes;
    byteT daaCorr;
    byteT daaRes;
    logic lowFix;
    logic highFix;

    assign incRes = operand + byteT'(1);
    assign decRes = operand - byteT'(1);

    // DAA adjusts on the nibbles of A and the flags left by the last add or subtract.
    assign lowFix  = curFlags.h || (operand[3:0] > 4'd9);
    assign highFix = curFlags.c || (operand > 8'h99);

    always_comb begin
        case ({highFix, lowFix})
            2'b01:   daaCorr = `Z80_DAA_LOW;
            2'b10:   daaCorr = `Z80_DAA_HIGH;
            2'b11:   daaCorr = `Z80_DAA_BOTH;
            default: daaCorr = '0;
        endcase
    end

    assign daaRes = curFlags.n ? (operand - daaCorr) : (operand + daaCorr);

    always_comb begin
        result   = operand;
        newFlags = curFlags;
        case (decodedOp.opClass)
            opInc: begin
                result      = incRes;
                newFlags.s  = incRes[7];
                newFlags.z  = (incRes == '0);
                newFlags.h  = (operand[3:0] == 4'hF); // Carry out of bit 3.
                newFlags.pv = (operand == 8'h7F);
                newFlags.n  = 1'b0;
            end
            opDec: begin
                result      = decRes;
                newFlags.s  = decRes[7];
                newFlags.z  = (decRes == '0);
                newFlags.h  = (operand[3:0] == 4'h0); // Borrow into bit 3.
                newFlags.pv = (operand == 8'h80);
                newFlags.n  = 1'b1;
            end
            opLoadImm: begin
                result = decodedOp.imm;
            end
            opRlca: begin
                result     = {operand[6:0], operand[7]};
                newFlags.c = operand[7];
                newFlags.h = 1'b0;
                newFlags.n = 1'b0;
            end
            opRrca: begin
                result     = {operand[0], operand[7:1]};
                newFlags.c = operand[0];
                newFlags.h = 1'b0;
                newFlags.n = 1'b0;
            end
            opRla: begin
                result     = {operand[6:0], curFlags.c}; // Rotate through carry.
                newFlags.c = operand[7];
                newFlags.h = 1'b0;
                newFlags.n = 1'b0;
            end
            opRra: begin
                result     = {curFlags.c, operand[7:1]};
                newFlags.c = operand[0];
                newFlags.h = 1'b0;
                newFlags.n = 1'b0;
            end
            opDaa: begin
                result      = daaRes;
                newFlags.s  = daaRes[7];
                newFlags.z  = (daaRes == '0);
                newFlags.h  = curFlags.n ? (curFlags.h && (operand[3:0] < 4'd6))
                                         : (operand[3:0] > 4'd9);
                newFlags.pv = ~^daaRes; // Even parity.
                newFlags.c  = highFix;
            end
            opCpl: begin
                result     = ~operand;
                newFlags.h = 1'b1;
                newFlags.n = 1'b1;
            end
            opScf: begin
                newFlags.c = 1'b1;
                newFlags.h = 1'b0;
                newFlags.n = 1'b0;
            end
            opCcf: begin
                newFlags.h = curFlags.c;
                newFlags.c = ~curFlags.c;
                newFlags.n = 1'b0;
            end
            default: begin
                result   = operand;
                newFlags = curFlags;
            end
        endcase
    end

    assign regWrite  = decodedOp.valid &&
                       (decodedOp.opClass != opScf) && (decodedOp.opClass != opCcf);
    assign flagWrite = decodedOp.valid && (decodedOp.opClass != opLoadImm);

endmodule

// File: decoder/opDecoder.sv
// Decode stage: turns a quadrant 0x00-0x3F opcode into a registered control word for execute.
`timescale 1ns/1ps
`include "z80_defs.svh"

module opDecoder
    import z80DataPkg::*;
    import z80OpcodePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      opValid,
    input  byteT      opcode,
    input  byteT      immediate,
    output decodedOpT decodedOp
);

    logic [1:0] xField;
    logic [2:0] yField;
    logic [2:0] zField;
    logic       yIsMem;

    opClassT nextClass;
    regIdxT  nextTarget;

    logic    validQ;
    opClassT opClassQ;
    regIdxT  targetQ;
    byteT    immQ;

    assign xField = opcode[7:6];
    assign yField = opcode[5:3];
    assign zField = opcode[2:0];
    assign yIsMem = (yField == `Z80_REG_HL_MEM); // (HL) operands are dropped.

    always_comb begin
        nextClass  = opNone;
        nextTarget = regA;
        if (xField == 2'b00) begin
            case (zField)
                zInc: begin
                    if (!yIsMem) begin
                        nextClass  = opInc;
                        nextTarget = yField;
                    end
                end
                zDec: begin
                    if (!yIsMem) begin
                        nextClass  = opDec;
                        nextTarget = yField;
                    end
                end
                zLoadImm: begin
                    if (!yIsMem) begin
                        nextClass  = opLoadImm;
                        nextTarget = yField;
                    end
                end
                zAccGroup: begin
                    case (yField)
                        yRlca:   nextClass = opRlca;
                        yRrca:   nextClass = opRrca;
                        yRla:    nextClass = opRla;
                        yRra:    nextClass = opRra;
                        yDaa:    nextClass = opDaa;
                        yCpl:    nextClass = opCpl;
                        yScf:    nextClass = opScf;
                        default: nextClass = opCcf;
                    endcase
                end
                default: nextClass = opNone; // Jumps, 16-bit and indirect ops.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validQ <= 1'b0;
        end else begin
            validQ <= opValid && (nextClass != opNone);
        end
    end

    always_ff @(posedge clk) begin
        opClassQ <= nextClass;
        targetQ  <= nextTarget;
        immQ     <= immediate;
    end

    assign decodedOp = '{valid: validQ, opClass: opClassQ, target: targetQ, imm: immQ};

endmodule

// File: common/z80OpcodePkg.sv
// Instruction-side types (operation class, decoded control word) shared by decode and execute.
package z80OpcodePkg;

    typedef enum logic [3:0] {
        opNone    = 4'd0,
        opInc     = 4'd1,
        opDec     = 4'd2,
        opLoadImm = 4'd3,
        opRlca    = 4'd4,
        opRrca    = 4'd5,
        opRla     = 4'd6,
        opRra     = 4'd7,
        opDaa     = 4'd8,
        opCpl     = 4'd9,
        opScf     = 4'd10,
        opCcf     = 4'd11
    } opClassT;

    // Low three opcode bits of the kept groups.
    localparam logic [2:0] zInc      = 3'b100;
    localparam logic [2:0] zDec      = 3'b101;
    localparam logic [2:0] zLoadImm  = 3'b110;
    localparam logic [2:0] zAccGroup = 3'b111;

    // Accumulator group, indexed by the y field.
    localparam logic [2:0] yRlca = 3'd0;
    localparam logic [2:0] yRrca = 3'd1;
    localparam logic [2:0] yRla  = 3'd2;
    localparam logic [2:0] yRra  = 3'd3;
    localparam logic [2:0] yDaa  = 3'd4;
    localparam logic [2:0] yCpl  = 3'd5;
    localparam logic [2:0] yScf  = 3'd6;
    localparam logic [2:0] yCcf  = 3'd7;

    // Control word handed from decode to execute, 16 bits.
    typedef struct packed {
        logic              valid;
        opClassT           opClass;
        z80DataPkg::regIdxT target;
        z80DataPkg::byteT   imm;
    } decodedOpT;

endpackage

// File: common/z80DataPkg.sv
// Data-side types (bytes, register codes, flags) imported by the quadrant unit and its testbench.
`include "z80_defs.svh"

package z80DataPkg;

    typedef logic [`Z80_DATA_W-1:0] byteT;

    // Z80 register order: B, C, D, E, H, L, (HL), A.
    typedef logic [$clog2(`Z80_REG_COUNT)-1:0] regIdxT;

    localparam regIdxT regB = 3'd0;
    localparam regIdxT regC = 3'd1;
    localparam regIdxT regD = 3'd2;
    localparam regIdxT regE = 3'd3;
    localparam regIdxT regH = 3'd4;
    localparam regIdxT regL = 3'd5;
    localparam regIdxT regA = 3'd7;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic pv;
        logic n;
        logic c;
    } flagsT;

endpackage

// File: common/z80_defs.svh
// Shared width, register, DAA and flag-position constants; include wherever they are needed.
`ifndef Z80_DEFS_SVH
`define Z80_DEFS_SVH

// Datapath.
`define Z80_DATA_W      8
`define Z80_REG_COUNT   8

// Register code of the (HL) memory operand, not supported by this unit.
`define Z80_REG_HL_MEM  3'd6

// DAA correction constants.
`define Z80_DAA_LOW     8'h06
`define Z80_DAA_HIGH    8'h60
`define Z80_DAA_BOTH    8'h66

// Bit positions inside the F byte.
`define Z80_FLAG_S      7
`define Z80_FLAG_Z      6
`define Z80_FLAG_H      4
`define Z80_FLAG_PV     2
`define Z80_FLAG_N      1
`define Z80_FLAG_C      0

`endif
